// File: compile.f
+incdir+.
fpu_pkg.sv
mult_norm_if.sv
fpu_regfile.sv
fpu_mult.sv
fpu_norm.sv
fpu_mult_unit.sv
tb_fpu_mult_unit.sv

// File: fpu_mult.sv
module fpu_mult (
    input  logic                               clock,
    input  logic                               arst_n,
    // start operation
    input  logic                               fpu_mult_start,
    // operands, straight from the regfile read ports
    input  logic [fpu_pkg::FP_WIDTH-1:0]       fpu_a,
    input  logic [fpu_pkg::FP_WIDTH-1:0]       fpu_b,
    // destination register
    input  logic [fpu_pkg::REG_ADDR_WIDTH-1:0] fpu_dest,
    mult_norm_if.producer                      out
);

    import fpu_pkg::*;

    // field split of both operands
    logic                  sign_a;
    logic                  sign_b;
    logic [EXP_WIDTH-1:0]  exp_a;
    logic [EXP_WIDTH-1:0]  exp_b;
    logic [FRAC_WIDTH:0]   sig_a;
    logic [FRAC_WIDTH:0]   sig_b;

    // stage one registers
    logic [2*FRAC_WIDTH+1:0]   mant_product;
    logic [EXP_WIDTH-1:0]      eff_exp_a;
    logic [EXP_WIDTH-1:0]      eff_exp_b;
    logic                      prod_sign;
    logic [REG_ADDR_WIDTH-1:0] dly_dest;
    logic                      dly_valid;

    // stage two exponent, two spare bits for carry and borrow
    logic [EXP_WIDTH+1:0] exp_sum;
    logic [EXP_WIDTH-1:0] exp_sat;

    assign sign_a = fpu_a[FP_WIDTH-1];
    assign sign_b = fpu_b[FP_WIDTH-1];
    assign exp_a  = fpu_a[FP_WIDTH-2 -: EXP_WIDTH];
    assign exp_b  = fpu_b[FP_WIDTH-2 -: EXP_WIDTH];

    // hidden one, dropped for denormals and zero
    assign sig_a = {|exp_a, fpu_a[FRAC_WIDTH-1:0]};
    assign sig_b = {|exp_b, fpu_b[FRAC_WIDTH-1:0]};

    // stage one: multiply and effective exponents
    always_ff @(posedge clock) begin
        mant_product <= sig_a * sig_b;
        // denormal exponent counts as 1
        eff_exp_a    <= (exp_a == '0) ? EXP_WIDTH'(1) : exp_a;
        eff_exp_b    <= (exp_b == '0) ? EXP_WIDTH'(1) : exp_b;
        prod_sign    <= sign_a ^ sign_b;
        dly_dest     <= fpu_dest;
    end

    // rebias the sum, wraps negative on underflow
    assign exp_sum = (EXP_WIDTH+2)'(eff_exp_a) + (EXP_WIDTH+2)'(eff_exp_b)
                   - (EXP_WIDTH+2)'(EXP_BIAS);

    // clamp to zero or the all ones code
    always_comb begin
        if (exp_sum[EXP_WIDTH+1]) begin
            exp_sat = '0;
        end else if (exp_sum >= (EXP_WIDTH+2)'(EXP_MAX)) begin
            exp_sat = EXP_WIDTH'(EXP_MAX);
        end else begin
            exp_sat = exp_sum[EXP_WIDTH-1:0];
        end
    end

    // stage two: keep top product bits, hand over to normalize
    always_ff @(posedge clock) begin
        out.mantissa <= mant_product[2*FRAC_WIDTH+1 -: PROD_KEEP];
        out.exponent <= exp_sat;
        out.sign     <= prod_sign;
        out.dest     <= dly_dest;
    end

    // valid delay line
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            dly_valid <= 1'b0;
            out.valid <= 1'b0;
        end else begin
            dly_valid <= fpu_mult_start;
            out.valid <= dly_valid;
        end
    end

    // product reaches normalize one cycle short of the full latency
    a_start_to_valid: assert property (
        @(posedge clock) disable iff (!arst_n)
        fpu_mult_start |-> ##(PIPE_LATENCY-1) out.valid
    ) else $error("fpu_mult: start not followed by valid");

    a_valid_from_start: assert property (
        @(posedge clock) disable iff (!arst_n)
        out.valid |-> $past(fpu_mult_start, PIPE_LATENCY-1)
    ) else $error("fpu_mult: valid without matching start");

endmodule

// File: fpu_mult_unit.sv
module fpu_mult_unit (
    input  logic                               clock,
    input  logic                               arst_n,
    // register load port
    input  logic                               load_valid,
    input  logic [fpu_pkg::REG_ADDR_WIDTH-1:0] load_addr,
    input  logic [fpu_pkg::FP_WIDTH-1:0]       load_data,
    // multiply issue
    input  logic                               mul_start,
    input  logic [fpu_pkg::REG_ADDR_WIDTH-1:0] mul_src_a,
    input  logic [fpu_pkg::REG_ADDR_WIDTH-1:0] mul_src_b,
    input  logic [fpu_pkg::REG_ADDR_WIDTH-1:0] mul_dest,
    // completed products, also written back to the regfile
    output logic                               result_valid,
    output logic [fpu_pkg::FP_WIDTH-1:0]       result_data,
    output logic [fpu_pkg::REG_ADDR_WIDTH-1:0] result_dest
);

    import fpu_pkg::*;

    // operands read in the start cycle
    logic [FP_WIDTH-1:0] op_a;
    logic [FP_WIDTH-1:0] op_b;

    // multiply to normalize hand-off
    mult_norm_if mn_if ();

    // result write-back lands one edge after result_valid,
    // so a source reading it is valid from the fourth cycle on
    fpu_regfile u_regfile (
        .clock        (clock),
        .load_valid   (load_valid),
        .load_addr    (load_addr),
        .load_data    (load_data),
        .result_valid (result_valid),
        .result_dest  (result_dest),
        .result_data  (result_data),
        .rd_addr_a    (mul_src_a),
        .rd_addr_b    (mul_src_b),
        .rd_data_a    (op_a),
        .rd_data_b    (op_b)
    );

    // two stages: multiply, then exponent and truncation
    fpu_mult u_mult (
        .clock          (clock),
        .arst_n         (arst_n),
        .fpu_mult_start (mul_start),
        .fpu_a          (op_a),
        .fpu_b          (op_b),
        .fpu_dest       (mul_dest),
        .out            (mn_if.producer)
    );

    // third stage: normalize, round, pack
    fpu_norm u_norm (
        .clock        (clock),
        .arst_n       (arst_n),
        .in           (mn_if.consumer),
        .result_valid (result_valid),
        .result_data  (result_data),
        .result_dest  (result_dest)
    );

endmodule

// File: fpu_norm.sv
module fpu_norm (
    input  logic                               clock,
    input  logic                               arst_n,
    mult_norm_if.consumer                      in,
    output logic                               result_valid,
    output logic [fpu_pkg::FP_WIDTH-1:0]       result_data,
    output logic [fpu_pkg::REG_ADDR_WIDTH-1:0] result_dest
);

    import fpu_pkg::*;

    // product in [2,4) when the top kept bit is set
    logic                  top_bit;
    // kept mantissa aligned so the leading one sits at bit PROD_KEEP-1
    logic [PROD_KEEP-1:0]  norm_mant;

    // fraction, guard and sticky taken below the leading one
    logic [FRAC_WIDTH-1:0] frac;
    logic                  guard;
    logic                  sticky;
    logic                  round_up;
    logic [FRAC_WIDTH:0]   frac_rnd;

    // exponent after normalize and rounding carry
    logic [EXP_WIDTH:0]    exp_final;
    logic                  is_zero;
    logic                  is_inf;
    logic [FP_WIDTH-1:0]   packed_word;

    assign top_bit = in.mantissa[PROD_KEEP-1];

    // without the top bit every field moves down one place
    assign norm_mant = top_bit ? in.mantissa : {in.mantissa[PROD_KEEP-2:0], 1'b0};

    assign frac   = norm_mant[PROD_KEEP-2 -: FRAC_WIDTH];
    assign guard  = norm_mant[PROD_KEEP-2-FRAC_WIDTH];
    // bits below the kept window are already gone
    assign sticky = |norm_mant[PROD_KEEP-3-FRAC_WIDTH:0];

    // round to nearest, ties to even
    assign round_up = guard & (sticky | frac[0]);
    assign frac_rnd = (FRAC_WIDTH+1)'(frac) + (FRAC_WIDTH+1)'(round_up);

    // fraction carry-out bumps the exponent, fraction wraps to zero
    assign exp_final = (EXP_WIDTH+1)'(in.exponent)
                     + (EXP_WIDTH+1)'(top_bit)
                     + (EXP_WIDTH+1)'(frac_rnd[FRAC_WIDTH]);

    // exponent 0 means underflow was saturated upstream
    assign is_zero = (in.exponent == '0) || (in.mantissa == '0);
    assign is_inf  = exp_final >= (EXP_WIDTH+1)'(EXP_MAX);

    always_comb begin
        if (is_zero) begin
            packed_word = {in.sign, {(FP_WIDTH-1){1'b0}}};
        end else if (is_inf) begin
            // signed infinity, zero fraction
            packed_word = {in.sign, EXP_WIDTH'(EXP_MAX), {FRAC_WIDTH{1'b0}}};
        end else begin
            packed_word = {in.sign, exp_final[EXP_WIDTH-1:0], frac_rnd[FRAC_WIDTH-1:0]};
        end
    end

    // result payload
    always_ff @(posedge clock) begin
        result_data <= packed_word;
        result_dest <= in.dest;
    end

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            result_valid <= 1'b0;
        end else begin
            result_valid <= in.valid;
        end
    end

    // one register stage between the interface and write-back
    a_valid_delay: assert property (
        @(posedge clock) disable iff (!arst_n)
        result_valid == $past(in.valid)
    ) else $error("fpu_norm: result_valid out of step with product valid");

endmodule

// File: fpu_pkg.sv
package fpu_pkg;

    // ieee 754 single precision layout
    localparam int FP_WIDTH   = 32;
    localparam int EXP_WIDTH  = 8;
    localparam int FRAC_WIDTH = 23;

    // biased exponent handling
    localparam int EXP_BIAS = 127;
    // all ones exponent, infinity
    localparam int EXP_MAX  = 255;

    // top product bits handed to normalize
    localparam int PROD_KEEP = 32;

    // register file geometry
    localparam int REG_ADDR_WIDTH = 5;
    localparam int REG_COUNT      = 32;

    // start to result_valid, in cycles
    localparam int PIPE_LATENCY = 3;

endpackage

// File: fpu_regfile.sv
module fpu_regfile (
    input  logic                               clock,
    // load port from outside
    input  logic                               load_valid,
    input  logic [fpu_pkg::REG_ADDR_WIDTH-1:0] load_addr,
    input  logic [fpu_pkg::FP_WIDTH-1:0]       load_data,
    // result write-back from the normalize stage
    input  logic                               result_valid,
    input  logic [fpu_pkg::REG_ADDR_WIDTH-1:0] result_dest,
    input  logic [fpu_pkg::FP_WIDTH-1:0]       result_data,
    // two asynchronous read ports
    input  logic [fpu_pkg::REG_ADDR_WIDTH-1:0] rd_addr_a,
    input  logic [fpu_pkg::REG_ADDR_WIDTH-1:0] rd_addr_b,
    output logic [fpu_pkg::FP_WIDTH-1:0]       rd_data_a,
    output logic [fpu_pkg::FP_WIDTH-1:0]       rd_data_b
);

    import fpu_pkg::*;

    // register storage, contents undefined until loaded
    logic [FP_WIDTH-1:0] regs [REG_COUNT];

    // single write port, muxed between load and result
    always_ff @(posedge clock) begin
        if (load_valid) begin
            regs[load_addr] <= load_data;
        end else if (result_valid) begin
            regs[result_dest] <= result_data;
        end
    end

    // reads see the old value on a same-cycle write
    assign rd_data_a = regs[rd_addr_a];
    assign rd_data_b = regs[rd_addr_b];

    // loads are scheduled by the host around in-flight multiplies,
    // the port has no arbitration of its own
    a_single_writer: assert property (
        @(posedge clock) !(load_valid && result_valid)
    ) else $error("regfile: load and result write in the same cycle");

endmodule

// File: mult_norm_if.sv
interface mult_norm_if;

    import fpu_pkg::*;

    // one item per cycle with valid high, no handshake
    logic                      valid;
    // kept upper product bits
    logic [PROD_KEEP-1:0]      mantissa;
    // biased, already saturated to 0 or EXP_MAX
    logic [EXP_WIDTH-1:0]      exponent;
    logic                      sign;
    // destination register tag
    logic [REG_ADDR_WIDTH-1:0] dest;

    modport producer (
        output valid,
        output mantissa,
        output exponent,
        output sign,
        output dest
    );

    modport consumer (
        input valid,
        input mantissa,
        input exponent,
        input sign,
        input dest
    );

endinterface

// File: run.sh
#!/bin/sh
# build and run the fpu multiply testbench with verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_fpu_mult_unit \
    -f compile.f \
    -o tb_fpu_mult_unit_sim

./obj_dir/tb_fpu_mult_unit_sim > sim.log 2>&1
cat sim.log

# the testbench prints the fail message on any failure
if grep -q "Some tests failed" sim.log; then
    exit 1
fi
exit 0

// File: fp_ref_model.svh
`ifndef FP_REF_MODEL_SVH
`define FP_REF_MODEL_SVH

// fixed seed for the stimulus generator
localparam logic [31:0] LCG_SEED = 32'd73111;

logic [31:0] lcg_state = LCG_SEED;

// numerical recipes lcg constants
function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
endfunction

// upper lcg bits are the better ones
function automatic int rand_range(input int lo, input int hi);
    logic [31:0] r;
    r = next_rand();
    return lo + int'(r[31:8]) % (hi - lo + 1);
endfunction

function automatic logic [31:0] make_float(input logic sign, input logic [7:0] exp_field,
                                           input logic [22:0] frac);
    return {sign, exp_field, frac};
endfunction

// random sign and fraction, exponent drawn from [lo, hi]
function automatic logic [31:0] make_normal(input int lo, input int hi);
    logic [31:0] r;
    logic [7:0]  e;
    r = next_rand();
    e = 8'(rand_range(lo, hi));
    return make_float(r[31], e, r[24:2]);
endfunction

function automatic logic [31:0] signed_zero(input logic sign);
    return {sign, 31'd0};
endfunction

function automatic logic [31:0] signed_inf(input logic sign);
    return {sign, 8'hff, 23'd0};
endfunction

// expected product of two words, 32 kept bits, round to nearest even
function automatic logic [31:0] fp_mul_model(input logic [31:0] a, input logic [31:0] b);
    logic        sign;
    logic [23:0] sig_a;
    logic [23:0] sig_b;
    logic [47:0] prod;
    logic [31:0] kept;
    logic [22:0] frac;
    logic        guard;
    logic        sticky;
    logic [23:0] rounded;
    int          ea;
    int          eb;
    int          e;
    sign  = a[31] ^ b[31];
    ea    = int'(a[30:23]);
    eb    = int'(b[30:23]);
    // no hidden one for a zero exponent field
    sig_a = {(ea != 0), a[22:0]};
    sig_b = {(eb != 0), b[22:0]};
    prod  = {24'd0, sig_a} * {24'd0, sig_b};
    kept  = prod[47:16];
    // denormals behave as exponent 1
    if (ea == 0) ea = 1;
    if (eb == 0) eb = 1;
    e = ea + eb - 127;
    if (e < 0) e = 0;
    if (e > 255) e = 255;
    if (e == 0 || kept == 32'd0) return signed_zero(sign);
    if (kept[31]) begin
        frac   = kept[30:8];
        guard  = kept[7];
        sticky = |kept[6:0];
        e      = e + 1;
    end else begin
        frac   = kept[29:7];
        guard  = kept[6];
        sticky = |kept[5:0];
    end
    rounded = {1'b0, frac} + 24'(guard && (sticky || frac[0]));
    // carry out of the fraction
    if (rounded[23]) e = e + 1;
    if (e >= 255) return signed_inf(sign);
    return {sign, 8'(e), rounded[22:0]};
endfunction

`endif

// File: tb_fpu_mult_unit.sv
module tb_fpu_mult_unit;

    timeunit 1ns;
    timeprecision 100ps;

    import fpu_pkg::*;

    localparam int CLK_HALF     = 20;
    localparam int DRIVE_DLY    = 2;
    localparam int RESET_CYCLES = 10;
    // operation counts including loads
    localparam int N_IDENT      = 8;
    localparam int N_RAND_REGS  = 16;
    localparam int N_RAND       = 40;
    localparam int N_ZERO       = 8;
    localparam int N_SAT        = 8;
    localparam int N_CHAIN      = 6;
    localparam int TOTAL_OPS    = (2 * N_IDENT + 1) + (N_RAND_REGS + N_RAND)
                                + (6 + N_ZERO) + (2 * N_SAT) + (4 + N_CHAIN);
    localparam int WATCHDOG_CYCLES = TOTAL_OPS * 8;

    logic                      clock;
    logic                      arst_n;
    logic                      load_valid;
    logic [REG_ADDR_WIDTH-1:0] load_addr;
    logic [FP_WIDTH-1:0]       load_data;
    logic                      mul_start;
    logic [REG_ADDR_WIDTH-1:0] mul_src_a;
    logic [REG_ADDR_WIDTH-1:0] mul_src_b;
    logic [REG_ADDR_WIDTH-1:0] mul_dest;
    logic                      result_valid;
    logic [FP_WIDTH-1:0]       result_data;
    logic [REG_ADDR_WIDTH-1:0] result_dest;

    `include "fp_ref_model.svh"

    // scoreboard, one entry per start in flight
    logic [FP_WIDTH-1:0]       exp_data_q [$];
    logic [REG_ADDR_WIDTH-1:0] exp_dest_q [$];
    int                        exp_cycle_q [$];
    // what the regfile should hold
    logic [FP_WIDTH-1:0]       reg_mirror [REG_COUNT];

    int cycle_count   = 0;
    int error_count   = 0;
    int check_count   = 0;
    int tests_run     = 0;
    int tests_failed  = 0;
    int test_err_base = 0;

    fpu_mult_unit UUT (
        .clock        (clock),
        .arst_n       (arst_n),
        .load_valid   (load_valid),
        .load_addr    (load_addr),
        .load_data    (load_data),
        .mul_start    (mul_start),
        .mul_src_a    (mul_src_a),
        .mul_src_b    (mul_src_b),
        .mul_dest     (mul_dest),
        .result_valid (result_valid),
        .result_data  (result_data),
        .result_dest  (result_dest)
    );

    initial begin
        clock = 1'b0;
        forever #CLK_HALF clock = ~clock;
    end

    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
    end

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("Error at %0d ns: %s expected %h, got %h", $time, name, expected, actual);
        end
    endtask

    // outputs are settled by the falling edge
    always @(negedge clock) begin
        logic [FP_WIDTH-1:0]       exp_word;
        logic [REG_ADDR_WIDTH-1:0] exp_dest;
        int                        start_cycle;
        if (arst_n && result_valid) begin
            if (exp_data_q.size() == 0) begin
                error_count++;
                $display("result for register %0d at %0d ns with no multiply outstanding",
                         result_dest, $time);
            end else begin
                exp_word    = exp_data_q.pop_front();
                exp_dest    = exp_dest_q.pop_front();
                start_cycle = exp_cycle_q.pop_front();
                check_value("result_data", exp_word, result_data);
                check_value("result_dest", 32'(exp_dest), 32'(result_dest));
                check_value("result latency", 32'(PIPE_LATENCY), 32'(cycle_count - start_cycle));
                // regfile takes it on the next rising edge
                reg_mirror[exp_dest] = exp_word;
            end
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clock);
        $display("watchdog: run not finished after %0d cycles, %0d results outstanding",
                 WATCHDOG_CYCLES, exp_data_q.size());
        $display("Some tests failed");
        $finish;
    end

    task automatic load_reg(input logic [REG_ADDR_WIDTH-1:0] addr, input logic [FP_WIDTH-1:0] data);
        load_valid = 1'b1;
        load_addr  = addr;
        load_data  = data;
        reg_mirror[addr] = data;
        @(posedge clock);
        #DRIVE_DLY;
        load_valid = 1'b0;
    endtask

    // latency counted from the cycle that carries the start
    task automatic issue_mul(input logic [REG_ADDR_WIDTH-1:0] src_a, src_b, dest,
                             input logic [FP_WIDTH-1:0] expected);
        mul_start = 1'b1;
        mul_src_a = src_a;
        mul_src_b = src_b;
        mul_dest  = dest;
        exp_data_q.push_back(expected);
        exp_dest_q.push_back(dest);
        exp_cycle_q.push_back(cycle_count);
        @(posedge clock);
        #DRIVE_DLY;
        mul_start = 1'b0;
    endtask

    // drain the pipe so loads never meet a write-back
    task automatic wait_idle();
        while (exp_data_q.size() != 0) @(negedge clock);
        @(posedge clock);
        #DRIVE_DLY;
    endtask

    task automatic end_test(input string name);
        int n;
        n = error_count - test_err_base;
        tests_run++;
        if (n == 0) begin
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: %0d mismatches", name, n);
        end
        test_err_base = error_count;
    endtask

    // x * 1.0 and 1.0 * x give x back
    task automatic test_identity();
        load_reg(0, 32'h3f80_0000);
        for (int i = 1; i <= N_IDENT; i++) load_reg(REG_ADDR_WIDTH'(i), make_normal(64, 190));
        for (int i = 1; i <= N_IDENT; i++) begin
            if (i % 2 == 0) begin
                issue_mul(REG_ADDR_WIDTH'(i), 0, REG_ADDR_WIDTH'(10 + i), reg_mirror[i]);
            end else begin
                issue_mul(0, REG_ADDR_WIDTH'(i), REG_ADDR_WIDTH'(10 + i), reg_mirror[i]);
            end
        end
        wait_idle();
        end_test("identity");
    endtask

    // back to back issue from sources 1..16 into 17..31
    task automatic test_random();
        logic [REG_ADDR_WIDTH-1:0] a;
        logic [REG_ADDR_WIDTH-1:0] b;
        logic [REG_ADDR_WIDTH-1:0] d;
        for (int i = 1; i <= N_RAND_REGS; i++) load_reg(REG_ADDR_WIDTH'(i), make_normal(64, 190));
        for (int i = 0; i < N_RAND; i++) begin
            a = REG_ADDR_WIDTH'(rand_range(1, N_RAND_REGS));
            b = REG_ADDR_WIDTH'(rand_range(1, N_RAND_REGS));
            d = REG_ADDR_WIDTH'(rand_range(N_RAND_REGS + 1, REG_COUNT - 1));
            issue_mul(a, b, d, fp_mul_model(reg_mirror[a], reg_mirror[b]));
        end
        wait_idle();
        end_test("random");
    endtask

    // +0 in r1, -0 in r2, normals in r3..r6
    task automatic test_zero();
        logic [REG_ADDR_WIDTH-1:0] z;
        logic [REG_ADDR_WIDTH-1:0] n;
        load_reg(1, 32'h0000_0000);
        load_reg(2, 32'h8000_0000);
        for (int i = 3; i <= 6; i++) load_reg(REG_ADDR_WIDTH'(i), make_normal(64, 190));
        for (int i = 0; i < N_ZERO; i++) begin
            z = REG_ADDR_WIDTH'(1 + i % 2);
            n = REG_ADDR_WIDTH'(3 + i / 2);
            if (i < N_ZERO / 2) begin
                issue_mul(z, n, REG_ADDR_WIDTH'(20 + i),
                          signed_zero(reg_mirror[z][31] ^ reg_mirror[n][31]));
            end else begin
                issue_mul(n, z, REG_ADDR_WIDTH'(20 + i),
                          signed_zero(reg_mirror[z][31] ^ reg_mirror[n][31]));
            end
        end
        wait_idle();
        end_test("zero operands");
    endtask

    // large pairs overflow, small pairs underflow
    task automatic test_saturation();
        logic [REG_ADDR_WIDTH-1:0] a;
        logic [REG_ADDR_WIDTH-1:0] b;
        for (int i = 1; i <= 4; i++) load_reg(REG_ADDR_WIDTH'(i), make_normal(200, 254));
        for (int i = 5; i <= 8; i++) load_reg(REG_ADDR_WIDTH'(i), make_normal(1, 60));
        for (int i = 0; i < N_SAT / 2; i++) begin
            a = REG_ADDR_WIDTH'(1 + i);
            b = REG_ADDR_WIDTH'(1 + (i + 1) % 4);
            issue_mul(a, b, REG_ADDR_WIDTH'(24 + i),
                      signed_inf(reg_mirror[a][31] ^ reg_mirror[b][31]));
        end
        for (int i = 0; i < N_SAT / 2; i++) begin
            a = REG_ADDR_WIDTH'(5 + i);
            b = REG_ADDR_WIDTH'(5 + (i + 1) % 4);
            issue_mul(a, b, REG_ADDR_WIDTH'(28 + i),
                      signed_zero(reg_mirror[a][31] ^ reg_mirror[b][31]));
        end
        wait_idle();
        end_test("saturation");
    endtask

    // each product feeds a later multiply with starts 5 cycles apart
    task automatic test_chained();
        int src_a [N_CHAIN] = '{1, 20, 21, 22, 23, 24};
        int src_b [N_CHAIN] = '{2, 3, 4, 20, 1, 21};
        logic [REG_ADDR_WIDTH-1:0] a;
        logic [REG_ADDR_WIDTH-1:0] b;
        for (int i = 1; i <= 4; i++) load_reg(REG_ADDR_WIDTH'(i), make_normal(117, 137));
        for (int i = 0; i < N_CHAIN; i++) begin
            a = REG_ADDR_WIDTH'(src_a[i]);
            b = REG_ADDR_WIDTH'(src_b[i]);
            issue_mul(a, b, REG_ADDR_WIDTH'(20 + i), fp_mul_model(reg_mirror[a], reg_mirror[b]));
            repeat (4) @(posedge clock);
            #DRIVE_DLY;
        end
        wait_idle();
        end_test("chained write-back");
    endtask

    initial begin
        arst_n     = 1'b0;
        load_valid = 1'b0;
        load_addr  = '0;
        load_data  = '0;
        mul_start  = 1'b0;
        mul_src_a  = '0;
        mul_src_b  = '0;
        mul_dest   = '0;
        repeat (RESET_CYCLES) @(posedge clock);
        #DRIVE_DLY;
        arst_n = 1'b1;
        @(posedge clock);
        #DRIVE_DLY;

        test_identity();
        test_random();
        test_zero();
        test_saturation();
        test_chained();

        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, check_count, error_count);
        if (error_count == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule
